/* verilog/itcm_pkg.sv */
// ITCM controller shared definitions

package itcm_pkg;

  //////////////////////////////
  // Address and data widths
  //////////////////////////////
  localparam int ITCM_ADDR_W   = 16;  // Byte address, 64 KB
  localparam int ITCM_DATA_W   = 64;  // RAM word
  localparam int ITCM_WMSK_W   = ITCM_DATA_W / 8;
  localparam int ITCM_WORD_LSB = 3;   // Byte offset bits inside a RAM word

  // Narrow side of the LSU
  localparam int LSU_DATA_W    = 32;
  localparam int LSU_WMSK_W    = LSU_DATA_W / 8;

  //////////////////////////////
  // Response stage states
  //////////////////////////////
  // RSP_LIVE reads the RAM output directly, RSP_HELD the holding register
  typedef enum logic [1:0] {
    RSP_IDLE = 2'd0,  // Nothing pending
    RSP_LIVE = 2'd1,  // Response on RAM output
    RSP_HELD = 2'd2   // Response from holding register
  } rsp_state_e;

endpackage

/* verilog/itcm_lsu_n2w.sv */
// LSU 32-bit to ITCM 64-bit converter

module itcm_lsu_n2w #(
  parameter int ADDR_W = itcm_pkg::ITCM_ADDR_W
) (
  input  logic                            i_clk,
  input  logic                            i_rst_n,

  // LSU command, narrow
  input  logic                            i_lsu_cmd_valid,
  output logic                            o_lsu_cmd_ready,
  input  logic [ADDR_W-1:0]               i_lsu_cmd_addr,
  input  logic                            i_lsu_cmd_read,
  input  logic [itcm_pkg::LSU_DATA_W-1:0] i_lsu_cmd_wdata,
  input  logic [itcm_pkg::LSU_WMSK_W-1:0] i_lsu_cmd_wmask,

  // LSU response, narrow
  output logic                            o_lsu_rsp_valid,
  input  logic                            i_lsu_rsp_ready,
  output logic [itcm_pkg::LSU_DATA_W-1:0] o_lsu_rsp_rdata,

  // Wide command towards the arbiter
  output logic                             o_wide_cmd_valid,
  input  logic                             i_wide_cmd_ready,
  output logic [ADDR_W-1:0]                o_wide_cmd_addr,
  output logic                             o_wide_cmd_read,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_wide_cmd_wdata,
  output logic [itcm_pkg::ITCM_WMSK_W-1:0] o_wide_cmd_wmask,

  // Wide response from the arbiter
  input  logic                             i_wide_rsp_valid,
  output logic                             o_wide_rsp_ready,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_wide_rsp_rdata
);
  import itcm_pkg::*;

  localparam int LANE_BIT = ITCM_WORD_LSB - 1;  // Selects upper 32 bits

  logic lane_vld;  // A lane bit waits for its response
  logic lane_hi;   // Stored address bit 2
  logic lane_ok;
  logic wide_cmd_hsk;
  logic wide_rsp_hsk;

  //////////////////////////////
  // Command side
  //////////////////////////////
  // No second command until the stored lane has been used
  assign wide_rsp_hsk = i_wide_rsp_valid & o_wide_rsp_ready;
  assign lane_ok      = ~lane_vld | wide_rsp_hsk;

  assign o_wide_cmd_valid = i_lsu_cmd_valid & lane_ok;
  assign o_lsu_cmd_ready  = i_wide_cmd_ready & lane_ok;
  assign wide_cmd_hsk     = o_wide_cmd_valid & i_wide_cmd_ready;

  assign o_wide_cmd_addr  = i_lsu_cmd_addr;
  assign o_wide_cmd_read  = i_lsu_cmd_read;
  assign o_wide_cmd_wdata = {2{i_lsu_cmd_wdata}};  // Same word in both halves

  // Byte mask follows address bit 2
  assign o_wide_cmd_wmask = i_lsu_cmd_addr[LANE_BIT] ?
                            {i_lsu_cmd_wmask, {LSU_WMSK_W{1'b0}}} :
                            {{LSU_WMSK_W{1'b0}}, i_lsu_cmd_wmask};

  //////////////////////////////
  // Lane flag
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      lane_vld <= 1'b0;
    end else if (wide_cmd_hsk) begin
      lane_vld <= 1'b1;  // Set wins over a same-cycle clear
    end else if (wide_rsp_hsk) begin
      lane_vld <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (wide_cmd_hsk) begin
      lane_hi <= i_lsu_cmd_addr[LANE_BIT];
    end
  end

  //////////////////////////////
  // Response side
  //////////////////////////////
  assign o_lsu_rsp_valid  = i_wide_rsp_valid;
  assign o_wide_rsp_ready = i_lsu_rsp_ready;
  assign o_lsu_rsp_rdata  = lane_hi ? i_wide_rsp_rdata[ITCM_DATA_W-1 -: LSU_DATA_W] :
                                      i_wide_rsp_rdata[LSU_DATA_W-1:0];

endmodule

/* verilog/itcm_cmd_arbiter.sv */
// LSU over IFU command arbiter

module itcm_cmd_arbiter #(
  parameter int ADDR_W = itcm_pkg::ITCM_ADDR_W
) (
  // IFU command and response
  input  logic                             i_ifu_cmd_valid,
  output logic                             o_ifu_cmd_ready,
  input  logic [ADDR_W-1:0]                i_ifu_cmd_addr,
  input  logic                             i_ifu_cmd_read,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_ifu_cmd_wdata,
  input  logic [itcm_pkg::ITCM_WMSK_W-1:0] i_ifu_cmd_wmask,
  output logic                             o_ifu_rsp_valid,
  input  logic                             i_ifu_rsp_ready,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_ifu_rsp_rdata,

  // Wide LSU command and response
  input  logic                             i_lsu_cmd_valid,
  output logic                             o_lsu_cmd_ready,
  input  logic [ADDR_W-1:0]                i_lsu_cmd_addr,
  input  logic                             i_lsu_cmd_read,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_lsu_cmd_wdata,
  input  logic [itcm_pkg::ITCM_WMSK_W-1:0] i_lsu_cmd_wmask,
  output logic                             o_lsu_rsp_valid,
  input  logic                             i_lsu_rsp_ready,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_lsu_rsp_rdata,

  // Merged command and response
  output logic                             o_mem_cmd_valid,
  input  logic                             i_mem_cmd_ready,
  output logic [ADDR_W-1:0]                o_mem_cmd_addr,
  output logic                             o_mem_cmd_read,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_mem_cmd_wdata,
  output logic [itcm_pkg::ITCM_WMSK_W-1:0] o_mem_cmd_wmask,
  output logic                             o_mem_cmd_ifu,
  input  logic                             i_mem_rsp_valid,
  output logic                             o_mem_rsp_ready,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_mem_rsp_rdata,
  input  logic                             i_mem_rsp_ifu
);
  import itcm_pkg::*;

  logic sel_lsu;
  logic sel_ifu;

  //////////////////////////////
  // Command select
  //////////////////////////////
  assign sel_lsu = i_lsu_cmd_valid;                     // LSU always first
  assign sel_ifu = i_ifu_cmd_valid & ~i_lsu_cmd_valid;

  assign o_lsu_cmd_ready = i_mem_cmd_ready;
  assign o_ifu_cmd_ready = i_mem_cmd_ready & ~i_lsu_cmd_valid;

  assign o_mem_cmd_valid = sel_lsu | sel_ifu;
  assign o_mem_cmd_ifu   = ~sel_lsu;  // Tag travels with the command

  assign o_mem_cmd_addr  = ({ADDR_W{sel_lsu}} & i_lsu_cmd_addr)
                         | ({ADDR_W{sel_ifu}} & i_ifu_cmd_addr);
  assign o_mem_cmd_read  = (sel_lsu & i_lsu_cmd_read)
                         | (sel_ifu & i_ifu_cmd_read);
  assign o_mem_cmd_wdata = ({ITCM_DATA_W{sel_lsu}} & i_lsu_cmd_wdata)
                         | ({ITCM_DATA_W{sel_ifu}} & i_ifu_cmd_wdata);
  assign o_mem_cmd_wmask = ({ITCM_WMSK_W{sel_lsu}} & i_lsu_cmd_wmask)
                         | ({ITCM_WMSK_W{sel_ifu}} & i_ifu_cmd_wmask);

  //////////////////////////////
  // Response routing by tag
  //////////////////////////////
  assign o_ifu_rsp_valid = i_mem_rsp_valid & i_mem_rsp_ifu;
  assign o_lsu_rsp_valid = i_mem_rsp_valid & ~i_mem_rsp_ifu;
  assign o_mem_rsp_ready = i_mem_rsp_ifu ? i_ifu_rsp_ready : i_lsu_rsp_ready;

  // Data goes to both, only the valid one matters
  assign o_ifu_rsp_rdata = i_mem_rsp_rdata;
  assign o_lsu_rsp_rdata = i_mem_rsp_rdata;

endmodule

/* verilog/itcm_sram_ctrl.sv */
// ITCM SRAM control and response stage

module itcm_sram_ctrl #(
  parameter  int ADDR_W = itcm_pkg::ITCM_ADDR_W,
  localparam int RAM_AW = ADDR_W - itcm_pkg::ITCM_WORD_LSB
) (
  input  logic                             i_clk,
  input  logic                             i_rst_n,

  // Merged command
  input  logic                             i_cmd_valid,
  output logic                             o_cmd_ready,
  input  logic [ADDR_W-1:0]                i_cmd_addr,
  input  logic                             i_cmd_read,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_cmd_wdata,
  input  logic [itcm_pkg::ITCM_WMSK_W-1:0] i_cmd_wmask,
  input  logic                             i_cmd_ifu,

  // Merged response
  output logic                             o_rsp_valid,
  input  logic                             i_rsp_ready,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_rsp_rdata,
  output logic                             o_rsp_ifu,

  // Single-port RAM
  output logic                             o_ram_cs,
  output logic                             o_ram_we,
  output logic [RAM_AW-1:0]                o_ram_addr,
  output logic [itcm_pkg::ITCM_WMSK_W-1:0] o_ram_wem,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_ram_dout,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_ram_din,

  output logic                             o_ifu_holdup,
  output logic                             o_busy
);
  import itcm_pkg::*;

  rsp_state_e             state_q;
  rsp_state_e             state_d;
  logic                   cmd_hsk;
  logic [ITCM_DATA_W-1:0] hold_q;     // RAM word kept under back-pressure
  logic                   rsp_ifu_q;
  logic                   holdup_q;

  //////////////////////////////
  // RAM command
  //////////////////////////////
  // A pending response blocks new commands until it is taken
  assign o_cmd_ready = (state_q == RSP_IDLE) | i_rsp_ready;
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;

  assign o_ram_cs   = cmd_hsk;
  assign o_ram_we   = cmd_hsk & ~i_cmd_read;
  assign o_ram_addr = i_cmd_addr[ADDR_W-1:ITCM_WORD_LSB];
  assign o_ram_wem  = i_cmd_read ? '0 : i_cmd_wmask;
  assign o_ram_din  = i_cmd_wdata;

  //////////////////////////////
  // Response FSM
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      RSP_IDLE: begin
        if (cmd_hsk) begin
          state_d = RSP_LIVE;
        end
      end
      RSP_LIVE, RSP_HELD: begin
        if (i_rsp_ready) begin
          state_d = cmd_hsk ? RSP_LIVE : RSP_IDLE;  // Back to back allowed
        end else begin
          state_d = RSP_HELD;
        end
      end
      default: state_d = RSP_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= RSP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture only on the first stalled cycle
  always_ff @(posedge i_clk) begin
    if ((state_q == RSP_LIVE) && !i_rsp_ready) begin
      hold_q <= i_ram_dout;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_hsk) begin
      rsp_ifu_q <= i_cmd_ifu;  // Requester tag of the access
    end
  end

  assign o_rsp_valid = (state_q != RSP_IDLE);
  assign o_rsp_rdata = (state_q == RSP_HELD) ? hold_q : i_ram_dout;
  assign o_rsp_ifu   = rsp_ifu_q;
  assign o_busy      = (state_q != RSP_IDLE);

  //////////////////////////////
  // IFU holdup
  //////////////////////////////
  // Set by a fetch, cleared by any LSU access to the RAM
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      holdup_q <= 1'b0;
    end else if (o_ram_cs) begin
      holdup_q <= i_cmd_ifu;
    end
  end

  assign o_ifu_holdup = holdup_q;

endmodule

/* verilog/itcm_ctrl.sv */
// ITCM controller top level

module itcm_ctrl #(
  parameter  int ADDR_W = itcm_pkg::ITCM_ADDR_W,
  localparam int RAM_AW = ADDR_W - itcm_pkg::ITCM_WORD_LSB
) (
  input  logic                             i_clk,
  input  logic                             i_rst_n,

  // IFU channels, 64 bits
  input  logic                             i_ifu_cmd_valid,
  output logic                             o_ifu_cmd_ready,
  input  logic [ADDR_W-1:0]                i_ifu_cmd_addr,
  input  logic                             i_ifu_cmd_read,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_ifu_cmd_wdata,
  input  logic [itcm_pkg::ITCM_WMSK_W-1:0] i_ifu_cmd_wmask,
  output logic                             o_ifu_rsp_valid,
  input  logic                             i_ifu_rsp_ready,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_ifu_rsp_rdata,

  // LSU channels, 32 bits
  input  logic                             i_lsu_cmd_valid,
  output logic                             o_lsu_cmd_ready,
  input  logic [ADDR_W-1:0]                i_lsu_cmd_addr,
  input  logic                             i_lsu_cmd_read,
  input  logic [itcm_pkg::LSU_DATA_W-1:0]  i_lsu_cmd_wdata,
  input  logic [itcm_pkg::LSU_WMSK_W-1:0]  i_lsu_cmd_wmask,
  output logic                             o_lsu_rsp_valid,
  input  logic                             i_lsu_rsp_ready,
  output logic [itcm_pkg::LSU_DATA_W-1:0]  o_lsu_rsp_rdata,

  output logic                             o_ifu_holdup,
  output logic                             o_itcm_active,

  // RAM
  output logic                             o_ram_cs,
  output logic                             o_ram_we,
  output logic [RAM_AW-1:0]                o_ram_addr,
  output logic [itcm_pkg::ITCM_WMSK_W-1:0] o_ram_wem,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_ram_din,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_ram_dout
);
  import itcm_pkg::*;

  //////////////////////////////
  // Internal channels
  //////////////////////////////
  logic                   wide_cmd_valid;  // LSU after width conversion
  logic                   wide_cmd_ready;
  logic [ADDR_W-1:0]      wide_cmd_addr;
  logic                   wide_cmd_read;
  logic [ITCM_DATA_W-1:0] wide_cmd_wdata;
  logic [ITCM_WMSK_W-1:0] wide_cmd_wmask;
  logic                   wide_rsp_valid;
  logic                   wide_rsp_ready;
  logic [ITCM_DATA_W-1:0] wide_rsp_rdata;

  logic                   mem_cmd_valid;   // Arbiter to SRAM control
  logic                   mem_cmd_ready;
  logic [ADDR_W-1:0]      mem_cmd_addr;
  logic                   mem_cmd_read;
  logic [ITCM_DATA_W-1:0] mem_cmd_wdata;
  logic [ITCM_WMSK_W-1:0] mem_cmd_wmask;
  logic                   mem_cmd_ifu;
  logic                   mem_rsp_valid;
  logic                   mem_rsp_ready;
  logic [ITCM_DATA_W-1:0] mem_rsp_rdata;
  logic                   mem_rsp_ifu;
  logic                   sram_busy;

  itcm_lsu_n2w #(
    .ADDR_W (ADDR_W)
  ) u_lsu_n2w (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_lsu_cmd_valid  (i_lsu_cmd_valid),
    .o_lsu_cmd_ready  (o_lsu_cmd_ready),
    .i_lsu_cmd_addr   (i_lsu_cmd_addr),
    .i_lsu_cmd_read   (i_lsu_cmd_read),
    .i_lsu_cmd_wdata  (i_lsu_cmd_wdata),
    .i_lsu_cmd_wmask  (i_lsu_cmd_wmask),
    .o_lsu_rsp_valid  (o_lsu_rsp_valid),
    .i_lsu_rsp_ready  (i_lsu_rsp_ready),
    .o_lsu_rsp_rdata  (o_lsu_rsp_rdata),
    .o_wide_cmd_valid (wide_cmd_valid),
    .i_wide_cmd_ready (wide_cmd_ready),
    .o_wide_cmd_addr  (wide_cmd_addr),
    .o_wide_cmd_read  (wide_cmd_read),
    .o_wide_cmd_wdata (wide_cmd_wdata),
    .o_wide_cmd_wmask (wide_cmd_wmask),
    .i_wide_rsp_valid (wide_rsp_valid),
    .o_wide_rsp_ready (wide_rsp_ready),
    .i_wide_rsp_rdata (wide_rsp_rdata)
  );

  itcm_cmd_arbiter #(
    .ADDR_W (ADDR_W)
  ) u_cmd_arbiter (
    .i_ifu_cmd_valid (i_ifu_cmd_valid),
    .o_ifu_cmd_ready (o_ifu_cmd_ready),
    .i_ifu_cmd_addr  (i_ifu_cmd_addr),
    .i_ifu_cmd_read  (i_ifu_cmd_read),
    .i_ifu_cmd_wdata (i_ifu_cmd_wdata),
    .i_ifu_cmd_wmask (i_ifu_cmd_wmask),
    .o_ifu_rsp_valid (o_ifu_rsp_valid),
    .i_ifu_rsp_ready (i_ifu_rsp_ready),
    .o_ifu_rsp_rdata (o_ifu_rsp_rdata),
    .i_lsu_cmd_valid (wide_cmd_valid),
    .o_lsu_cmd_ready (wide_cmd_ready),
    .i_lsu_cmd_addr  (wide_cmd_addr),
    .i_lsu_cmd_read  (wide_cmd_read),
    .i_lsu_cmd_wdata (wide_cmd_wdata),
    .i_lsu_cmd_wmask (wide_cmd_wmask),
    .o_lsu_rsp_valid (wide_rsp_valid),
    .i_lsu_rsp_ready (wide_rsp_ready),
    .o_lsu_rsp_rdata (wide_rsp_rdata),
    .o_mem_cmd_valid (mem_cmd_valid),
    .i_mem_cmd_ready (mem_cmd_ready),
    .o_mem_cmd_addr  (mem_cmd_addr),
    .o_mem_cmd_read  (mem_cmd_read),
    .o_mem_cmd_wdata (mem_cmd_wdata),
    .o_mem_cmd_wmask (mem_cmd_wmask),
    .o_mem_cmd_ifu   (mem_cmd_ifu),
    .i_mem_rsp_valid (mem_rsp_valid),
    .o_mem_rsp_ready (mem_rsp_ready),
    .i_mem_rsp_rdata (mem_rsp_rdata),
    .i_mem_rsp_ifu   (mem_rsp_ifu)
  );

  itcm_sram_ctrl #(
    .ADDR_W (ADDR_W)
  ) u_sram_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_valid  (mem_cmd_valid),
    .o_cmd_ready  (mem_cmd_ready),
    .i_cmd_addr   (mem_cmd_addr),
    .i_cmd_read   (mem_cmd_read),
    .i_cmd_wdata  (mem_cmd_wdata),
    .i_cmd_wmask  (mem_cmd_wmask),
    .i_cmd_ifu    (mem_cmd_ifu),
    .o_rsp_valid  (mem_rsp_valid),
    .i_rsp_ready  (mem_rsp_ready),
    .o_rsp_rdata  (mem_rsp_rdata),
    .o_rsp_ifu    (mem_rsp_ifu),
    .o_ram_cs     (o_ram_cs),
    .o_ram_we     (o_ram_we),
    .o_ram_addr   (o_ram_addr),
    .o_ram_wem    (o_ram_wem),
    .i_ram_dout   (i_ram_dout),
    .o_ram_din    (o_ram_din),
    .o_ifu_holdup (o_ifu_holdup),
    .o_busy       (sram_busy)
  );

  // Anything requested or still in flight
  assign o_itcm_active = i_ifu_cmd_valid | i_lsu_cmd_valid | sram_busy;

endmodule

/* sim/itcm_ram_model.sv */
// Single-port RAM model for the ITCM

module itcm_ram_model #(
  parameter int AW = 13
) (
  input  logic                             i_clk,
  input  logic                             i_cs,
  input  logic                             i_we,
  input  logic [AW-1:0]                    i_addr,
  input  logic [itcm_pkg::ITCM_WMSK_W-1:0] i_wem,
  input  logic [itcm_pkg::ITCM_DATA_W-1:0] i_din,
  output logic [itcm_pkg::ITCM_DATA_W-1:0] o_dout
);
  timeunit 1ns;
  timeprecision 100ps;

  import itcm_pkg::*;

  localparam int DEPTH = 1 << AW;

  logic [ITCM_DATA_W-1:0] mem [DEPTH];

  // Fill pattern from the full word address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {32'(i) ^ 32'ha5c3_0000, ~32'(i)};
    end
    o_dout = '0;
  end

  always @(posedge i_clk) begin
    if (i_cs) begin
      if (i_we) begin
        for (int b = 0; b < ITCM_WMSK_W; b++) begin
          if (i_wem[b]) mem[i_addr][8*b +: 8] <= i_din[8*b +: 8];
        end
      end else begin
        o_dout <= mem[i_addr];  // Registered read held until the next read
      end
    end
  end

endmodule

/* sim/tb_itcm_ctrl.sv */
// ITCM controller testbench

module tb_itcm_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  import itcm_pkg::*;

  localparam int ADDR_W      = ITCM_ADDR_W;
  localparam int RAM_AW      = ADDR_W - ITCM_WORD_LSB;
  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 4;
  localparam int N_WORDS     = 16;   // Test region in RAM words
  localparam int N_OPS       = 150;  // Random commands per requester
  localparam int OP_CYCLES   = 8;    // Generous cycles per command
  localparam int TEST_CYCLES = RST_CYCLES + 1 + 2 * N_WORDS * 3 + 2 * N_OPS * OP_CYCLES + 20;
  localparam logic [ADDR_W-1:0] REGION_BASE = 16'h3c00;

  logic clk = 1'b0;
  logic rst_n;
  logic ifu_cmd_valid, ifu_cmd_ready, ifu_cmd_read;
  logic [ADDR_W-1:0] ifu_cmd_addr;
  logic [ITCM_DATA_W-1:0] ifu_cmd_wdata, ifu_rsp_rdata;
  logic [ITCM_WMSK_W-1:0] ifu_cmd_wmask;
  logic ifu_rsp_valid, ifu_rsp_ready;
  logic lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read;
  logic [ADDR_W-1:0] lsu_cmd_addr;
  logic [LSU_DATA_W-1:0] lsu_cmd_wdata, lsu_rsp_rdata;
  logic [LSU_WMSK_W-1:0] lsu_cmd_wmask;
  logic lsu_rsp_valid, lsu_rsp_ready;
  logic ifu_holdup, itcm_active;
  logic ram_cs, ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [ITCM_WMSK_W-1:0] ram_wem;
  logic [ITCM_DATA_W-1:0] ram_din, ram_dout;

  // Reference model state
  logic [ITCM_DATA_W-1:0] shadow [N_WORDS];
  logic [ITCM_DATA_W-1:0] exp_ifu;
  logic [LSU_DATA_W-1:0]  exp_lsu;
  logic exp_ifu_rd, exp_lsu_rd;
  logic ifu_pend, lsu_pend;    // Response owed to each requester
  logic stim_done;
  int   err_cnt = 0;
  int   n_cmd = 0;
  int   n_rsp = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  itcm_ctrl #(.ADDR_W(ADDR_W)) uut (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_ifu_cmd_valid (ifu_cmd_valid), .o_ifu_cmd_ready (ifu_cmd_ready),
    .i_ifu_cmd_addr (ifu_cmd_addr), .i_ifu_cmd_read (ifu_cmd_read),
    .i_ifu_cmd_wdata (ifu_cmd_wdata), .i_ifu_cmd_wmask (ifu_cmd_wmask),
    .o_ifu_rsp_valid (ifu_rsp_valid), .i_ifu_rsp_ready (ifu_rsp_ready),
    .o_ifu_rsp_rdata (ifu_rsp_rdata),
    .i_lsu_cmd_valid (lsu_cmd_valid), .o_lsu_cmd_ready (lsu_cmd_ready),
    .i_lsu_cmd_addr (lsu_cmd_addr), .i_lsu_cmd_read (lsu_cmd_read),
    .i_lsu_cmd_wdata (lsu_cmd_wdata), .i_lsu_cmd_wmask (lsu_cmd_wmask),
    .o_lsu_rsp_valid (lsu_rsp_valid), .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp_rdata (lsu_rsp_rdata),
    .o_ifu_holdup (ifu_holdup), .o_itcm_active (itcm_active),
    .o_ram_cs (ram_cs), .o_ram_we (ram_we), .o_ram_addr (ram_addr),
    .o_ram_wem (ram_wem), .o_ram_din (ram_din), .i_ram_dout (ram_dout)
  );

  itcm_ram_model #(.AW(RAM_AW)) u_ram (
    .i_clk (clk), .i_cs (ram_cs), .i_we (ram_we), .i_addr (ram_addr),
    .i_wem (ram_wem), .i_din (ram_din), .o_dout (ram_dout)
  );

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic int word_index(input logic [ADDR_W-1:0] addr);
    return int'(addr[6:3]);
  endfunction

  // Byte-wise merge under a write mask
  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] mask);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr(input bit aligned);
    logic [6:0] off;
    off = 7'($urandom);
    if (aligned) off[2:0] = 3'd0;
    return REGION_BASE | ADDR_W'(off);
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  always @(posedge clk) begin
    logic [63:0] word;
    if (!rst_n) begin
      ifu_pend <= 1'b0;
      lsu_pend <= 1'b0;
    end else begin
      if (ifu_rsp_valid && ifu_rsp_ready) begin
        ifu_pend <= 1'b0;
        n_rsp++;
      end
      if (lsu_rsp_valid && lsu_rsp_ready) begin
        lsu_pend <= 1'b0;
        n_rsp++;
      end
      if (ifu_cmd_valid && ifu_cmd_ready) begin
        n_cmd++;
        ifu_pend   <= 1'b1;  // Set wins over a same-edge clear
        exp_ifu_rd <= ifu_cmd_read;
        exp_ifu    <= shadow[word_index(ifu_cmd_addr)];
        if (!ifu_cmd_read) begin
          shadow[word_index(ifu_cmd_addr)] = merge_bytes(shadow[word_index(ifu_cmd_addr)],
                                                         ifu_cmd_wdata, ifu_cmd_wmask);
        end
      end
      if (lsu_cmd_valid && lsu_cmd_ready) begin
        n_cmd++;
        word       = shadow[word_index(lsu_cmd_addr)];
        lsu_pend   <= 1'b1;
        exp_lsu_rd <= lsu_cmd_read;
        exp_lsu    <= lsu_cmd_addr[2] ? word[63:32] : word[31:0];
        if (!lsu_cmd_read) begin
          shadow[word_index(lsu_cmd_addr)] = merge_bytes(word, {2{lsu_cmd_wdata}},
              lsu_cmd_addr[2] ? {lsu_cmd_wmask, 4'h0} : {4'h0, lsu_cmd_wmask});
        end
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_ifu_data: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_rsp_valid && exp_ifu_rd) |-> ifu_rsp_rdata == exp_ifu)
    else flag_error($sformatf("IFU read data %h, expected %h", ifu_rsp_rdata, exp_ifu));
  a_lsu_data: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_rsp_valid && exp_lsu_rd) |-> lsu_rsp_rdata == exp_lsu)
    else flag_error($sformatf("LSU read data %h, expected %h", lsu_rsp_rdata, exp_lsu));
  a_priority: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_cmd_valid |-> !ifu_cmd_ready)
    else flag_error("IFU command ready while LSU command valid");
  a_ram_cs: assert property (@(posedge clk) disable iff (!rst_n)
    ram_cs == ((ifu_cmd_valid && ifu_cmd_ready) || (lsu_cmd_valid && lsu_cmd_ready)))
    else flag_error("RAM chip select does not match the command handshake");
  a_ifu_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_cmd_valid && ifu_cmd_ready) |=> ifu_rsp_valid)
    else flag_error("IFU response not valid one cycle after its command");
  a_lsu_lat: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_cmd_valid && lsu_cmd_ready) |=> lsu_rsp_valid)
    else flag_error("LSU response not valid one cycle after its command");
  a_ifu_owed: assert property (@(posedge clk) disable iff (!rst_n)
    ifu_rsp_valid |-> ifu_pend)
    else flag_error("IFU response without an IFU command");
  a_lsu_owed: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_rsp_valid |-> lsu_pend)
    else flag_error("LSU response without an LSU command");
  a_ifu_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_rsp_valid && !ifu_rsp_ready) |=> (ifu_rsp_valid && $stable(ifu_rsp_rdata)))
    else flag_error("IFU response changed while stalled");
  a_lsu_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_rsp_valid && !lsu_rsp_ready) |=> (lsu_rsp_valid && $stable(lsu_rsp_rdata)))
    else flag_error("LSU response changed while stalled");
  a_stall_blk: assert property (@(posedge clk) disable iff (!rst_n)
    ((ifu_rsp_valid && !ifu_rsp_ready) || (lsu_rsp_valid && !lsu_rsp_ready))
    |-> (!ifu_cmd_ready && !lsu_cmd_ready))
    else flag_error("Command ready high while a response is stalled");
  a_holdup_set: assert property (@(posedge clk) disable iff (!rst_n)
    (ifu_cmd_valid && ifu_cmd_ready) |=> ifu_holdup)
    else flag_error("Holdup low after an IFU command");
  a_holdup_clr: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_cmd_valid && lsu_cmd_ready) |=> !ifu_holdup)
    else flag_error("Holdup high after an LSU command");
  a_active: assert property (@(posedge clk) disable iff (!rst_n)
    itcm_active == (ifu_cmd_valid || lsu_cmd_valid || ifu_rsp_valid || lsu_rsp_valid))
    else flag_error($sformatf("Active output %b does not match activity", itcm_active));
  a_reset: assert property (@(posedge clk)
    !rst_n |=> (!ifu_rsp_valid && !lsu_rsp_valid && !ifu_holdup && !itcm_active && !ram_cs))
    else flag_error("Outputs not idle during or after reset");

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  // Tasks start and end 2 ns after a rising edge
  task automatic drive_ifu(input bit rd, input logic [ADDR_W-1:0] addr,
                           input logic [63:0] data, input logic [7:0] mask);
    ifu_cmd_valid = 1'b1;
    ifu_cmd_read  = rd;
    ifu_cmd_addr  = addr;
    ifu_cmd_wdata = data;
    ifu_cmd_wmask = mask;
    @(posedge clk);
    while (!ifu_cmd_ready) @(posedge clk);
    #2 ifu_cmd_valid = 1'b0;
  endtask

  task automatic drive_lsu(input bit rd, input logic [ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic [3:0] mask);
    lsu_cmd_valid = 1'b1;
    lsu_cmd_read  = rd;
    lsu_cmd_addr  = addr;
    lsu_cmd_wdata = data;
    lsu_cmd_wmask = mask;
    @(posedge clk);
    while (!lsu_cmd_ready) @(posedge clk);
    #2 lsu_cmd_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic run_ifu_random();
    for (int i = 0; i < N_OPS; i++) begin
      idle_cycles($urandom % 3);
      drive_ifu(1'($urandom), rand_addr(1'b1), {$urandom, $urandom}, 8'($urandom));
    end
  endtask

  task automatic run_lsu_random();
    for (int i = 0; i < N_OPS; i++) begin
      idle_cycles($urandom % 3);
      drive_lsu(1'($urandom), rand_addr(1'b0), $urandom, 4'($urandom));
    end
  endtask

  task automatic stall_responses();
    while (!stim_done) begin
      @(posedge clk);
      #2;
      ifu_rsp_ready = ($urandom % 4) != 0;  // Stall about one cycle in four
      lsu_rsp_ready = ($urandom % 4) != 0;
    end
    ifu_rsp_ready = 1'b1;
    lsu_rsp_ready = 1'b1;
  endtask

  task automatic drain();
    while (ifu_pend || lsu_pend || ifu_rsp_valid || lsu_rsp_valid) @(posedge clk);
    #2;
  endtask

  initial begin
    void'($urandom(32'h7ca125f0));
    rst_n = 1'b0;
    stim_done = 1'b0;
    ifu_cmd_valid = 1'b0;
    ifu_cmd_read  = 1'b1;
    ifu_cmd_addr  = '0;
    ifu_cmd_wdata = '0;
    ifu_cmd_wmask = '0;
    ifu_rsp_ready = 1'b1;
    lsu_cmd_valid = 1'b0;
    lsu_cmd_read  = 1'b1;
    lsu_cmd_addr  = '0;
    lsu_cmd_wdata = '0;
    lsu_cmd_wmask = '0;
    lsu_rsp_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;
    idle_cycles(1);

    // Known contents for the whole test region
    for (int i = 0; i < N_WORDS; i++) begin
      drive_ifu(1'b0, REGION_BASE + ADDR_W'(8 * i), {$urandom, $urandom}, 8'hff);
    end

    // Both requesters compete under random response stalls
    fork
      begin
        fork
          run_ifu_random();
          run_lsu_random();
        join
        stim_done = 1'b1;
      end
      stall_responses();
    join
    drain();

    // Full readback shows every masked write
    for (int i = 0; i < N_WORDS; i++) begin
      drive_ifu(1'b1, REGION_BASE + ADDR_W'(8 * i), '0, '0);
    end
    drain();
    idle_cycles(3);

    if (n_rsp != n_cmd) begin
      flag_error($sformatf("Response count %0d does not match command count %0d",
                           n_rsp, n_cmd));
    end
    $display("Summary: %0d commands, %0d responses, %0d errors", n_cmd, n_rsp, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 3 / 2);
    $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES * 3 / 2);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* all.f */
verilog/itcm_pkg.sv
verilog/itcm_lsu_n2w.sv
verilog/itcm_cmd_arbiter.sv
verilog/itcm_sram_ctrl.sv
verilog/itcm_ctrl.sv
sim/itcm_ram_model.sv
sim/tb_itcm_ctrl.sv
